//--- design/muldiv_settings.svh
`ifndef MULDIV_SETTINGS_SVH
`define MULDIV_SETTINGS_SVH

// operand and result width, RV32 only
`define MULDIV_XW 32

// major opcode OP, register-register integer group
`define MULDIV_OPC_OP 7'b0110011

// funct7 marking the M extension inside OP
`define MULDIV_F7_M 7'b0000001

`endif

//--- design/riscv_m_pkg.sv
package riscv_m_pkg;

  `include "muldiv_settings.svh"

  // operand and result word
  typedef logic [`MULDIV_XW-1:0] xw_t;

  // register file index, x0..x31
  typedef logic [4:0] reg_idx_t;

  // result select
  // low product, high product, quotient, remainder
  typedef enum logic [1:0]
  {
    M_MUL = 2'b00,
    M_MUH = 2'b01,
    M_DIV = 2'b10,
    M_REM = 2'b11
  } m_op_t;

  // decoded M control
  // s12[1] is rs1 signed, s12[0] is rs2 signed
  // legal: 00 unsigned, 10 signed x unsigned, 11 signed
  // division only ever sees 00 or 11
  typedef struct packed
  {
    m_op_t      op;
    logic [1:0] s12;
  } ctl_m_t;

endpackage

//--- design/m_issue_if.sv
`timescale 1ns/1ps

// one decoded instruction, decode register to execute and retire
interface m_issue_if
  import riscv_m_pkg::*;
();

  // legal M instruction in flight
  logic     valid;
  // strobed word was not an M instruction
  logic     illegal;
  ctl_m_t   ctl;
  xw_t      rs1;
  xw_t      rs2;
  reg_idx_t rd_idx;

  // decode owns the whole bundle
  modport issue (output valid, output illegal, output ctl,
                 output rs1, output rs2, output rd_idx);

  // datapath only needs control and operands
  modport exec (input ctl, input rs1, input rs2);

  // completion side
  modport retire (input valid, input illegal, input rd_idx);

endinterface

//--- design/m_decode.sv
`timescale 1ns/1ps

`include "muldiv_settings.svh"

module m_decode
  import riscv_m_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  logic [31:0] instr,
  input  xw_t         rs1,
  input  xw_t         rs2,
  m_issue_if.issue    issue
);

  // instruction fields, R-type layout
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd_field;

  // word passes the M check
  logic       is_m;
  ctl_m_t     ctl_next;

  assign opcode   = instr[6:0];
  assign rd_field = instr[11:7];
  assign funct3   = instr[14:12];
  assign funct7   = instr[31:25];

  // OP major opcode with the MULDIV funct7
  assign is_m = (opcode == `MULDIV_OPC_OP) && (funct7 == `MULDIV_F7_M);

  // funct3 to result select and operand signedness
  always_comb
  begin
    case (funct3)
      // MUL, low half same for any signedness
      3'b000: ctl_next = '{op: M_MUL, s12: 2'b11};
      // MULH
      3'b001: ctl_next = '{op: M_MUH, s12: 2'b11};
      // MULHSU, rs1 signed, rs2 unsigned
      3'b010: ctl_next = '{op: M_MUH, s12: 2'b10};
      // MULHU
      3'b011: ctl_next = '{op: M_MUH, s12: 2'b00};
      // DIV
      3'b100: ctl_next = '{op: M_DIV, s12: 2'b11};
      // DIVU
      3'b101: ctl_next = '{op: M_DIV, s12: 2'b00};
      // REM
      3'b110: ctl_next = '{op: M_REM, s12: 2'b11};
      // REMU
      default: ctl_next = '{op: M_REM, s12: 2'b00};
    endcase
  end

  // strobe flags, one of the two per accepted word
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      issue.valid   <= 1'b0;
      issue.illegal <= 1'b0;
    end
    else
    begin
      issue.valid   <= start & is_m;
      issue.illegal <= start & ~is_m;
    end
  end

  // payload, loaded every cycle, qualified by the flags
  always_ff @(posedge clk)
  begin
    issue.ctl    <= ctl_next;
    issue.rs1    <= rs1;
    issue.rs2    <= rs2;
    issue.rd_idx <= rd_field;
  end

endmodule

//--- design/m_execute.sv
`timescale 1ns/1ps

`include "muldiv_settings.svh"

module m_execute
  import riscv_m_pkg::*;
(
  m_issue_if.exec issue,
  output xw_t     value
);

  // double width for the full product
  localparam int unsigned DW = 2 * `MULDIV_XW;

  // most negative value
  localparam xw_t MIN_NEG = {1'b1, {(`MULDIV_XW-1){1'b0}}};
  // minus one
  localparam xw_t MINUS_ONE = '1;

  logic [DW-1:0]               mul;
  logic                        rs2_zero;
  logic                        div_ovf;
  xw_t                         divu;
  xw_t                         remu;
  logic signed [`MULDIV_XW-1:0] divs;
  logic signed [`MULDIV_XW-1:0] rems;
  xw_t                         div;
  xw_t                         rem;

  // operands widened to DW before the multiply
  // rs1 sign extended when signed, so mixed sign works too
  always_comb
  begin
    case (issue.ctl.s12)
      2'b00:
        mul = DW'($unsigned(issue.rs1)) * DW'($unsigned(issue.rs2));
      2'b10:
        mul = DW'($signed(issue.rs1)) * DW'($unsigned(issue.rs2));
      default:
        mul = DW'($signed(issue.rs1)) * DW'($signed(issue.rs2));
    endcase
  end

  // corner case detect
  assign rs2_zero = ~|issue.rs2;
  assign div_ovf  = (issue.rs1 == MIN_NEG) && (issue.rs2 == MINUS_ONE);

  // raw quotients and remainders
  // signed results land in signed vectors
  always_comb
  begin
    divu = $unsigned(issue.rs1) / $unsigned(issue.rs2);
    remu = $unsigned(issue.rs1) % $unsigned(issue.rs2);
    divs = $signed(issue.rs1) / $signed(issue.rs2);
    rems = $signed(issue.rs1) % $signed(issue.rs2);
  end

  // divide by zero: quotient all ones, remainder is the dividend
  // signed overflow: quotient MIN_NEG, remainder zero
  always_comb
  begin
    if (issue.ctl.s12 == 2'b00)
    begin
      div = rs2_zero ? '1 : divu;
      rem = rs2_zero ? issue.rs1 : remu;
    end
    else if (rs2_zero)
    begin
      div = '1;
      rem = issue.rs1;
    end
    else if (div_ovf)
    begin
      div = MIN_NEG;
      rem = '0;
    end
    else
    begin
      div = divs;
      rem = rems;
    end
  end

  // final result select
  always_comb
  begin
    case (issue.ctl.op)
      M_MUL:   value = mul[`MULDIV_XW-1:0];
      M_MUH:   value = mul[DW-1:`MULDIV_XW];
      M_DIV:   value = div;
      default: value = rem;
    endcase
  end

endmodule

//--- design/m_result.sv
`timescale 1ns/1ps

module m_result
  import riscv_m_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  m_issue_if.retire   issue,
  input  xw_t         value,
  output logic        done,
  output logic        illegal,
  output reg_idx_t    rd_idx,
  output xw_t         rd
);

  // x0 is hardwired zero
  logic rd_is_x0;
  xw_t  rd_next;

  assign rd_is_x0 = (issue.rd_idx == '0);
  assign rd_next  = rd_is_x0 ? '0 : value;

  // completion strobes, single cycle each
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      done    <= 1'b0;
      illegal <= 1'b0;
    end
    else
    begin
      done    <= issue.valid;
      illegal <= issue.illegal;
    end
  end

  // destination and data
  // only meaningful while done is high
  always_ff @(posedge clk)
  begin
    rd_idx <= issue.rd_idx;
    rd     <= rd_next;
  end

endmodule

//--- design/muldiv_unit.sv
`timescale 1ns/1ps

// RV32M multiply/divide unit
// fixed two cycle latency, accepts a word every cycle
module muldiv_unit
  import riscv_m_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  // instruction strobe with raw word and operands
  input  logic        start,
  input  logic [31:0] instr,
  input  xw_t         rs1,
  input  xw_t         rs2,
  // completion
  output logic        done,
  output logic        illegal,
  output reg_idx_t    rd_idx,
  output xw_t         rd
);

  // execute result into the retire register
  xw_t exec_value;

  // decoded instruction bundle
  m_issue_if issue_bus ();

  // stage 1, field check and operand register
  m_decode u_decode
  (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .instr (instr),
    .rs1   (rs1),
    .rs2   (rs2),
    .issue (issue_bus.issue)
  );

  // combinational multiply and divide
  m_execute u_execute
  (
    .issue (issue_bus.exec),
    .value (exec_value)
  );

  // stage 2, result register and strobes
  m_result u_result
  (
    .clk     (clk),
    .reset   (reset),
    .issue   (issue_bus.retire),
    .value   (exec_value),
    .done    (done),
    .illegal (illegal),
    .rd_idx  (rd_idx),
    .rd      (rd)
  );

endmodule

//--- testbench/muldiv_unit_props.sv
`timescale 1ns/1ps

// strobe protocol on the unit's top-level ports
module muldiv_unit_props
(
  input logic clk,
  input logic reset,
  input logic start,
  input logic done,
  input logic illegal
);

  // one completion strobe at a time
  a_strobe_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(done && illegal))
    else $error("done and illegal are high in the same cycle");

  // every accepted word retires two cycles later
  a_start_retires: assert property (@(posedge clk) disable iff (reset)
    start |-> ##2 (done || illegal))
    else $error("start was not followed by done or illegal two cycles later");

  // no strobe without a start two cycles back
  a_strobe_has_start: assert property (@(posedge clk) disable iff (reset)
    (done || illegal) |-> $past(start, 2))
    else $error("done or illegal raised without a start two cycles earlier");

  // strobes held low through reset
  a_reset_quiet: assert property (@(posedge clk)
    reset |=> (!done && !illegal))
    else $error("done or illegal high while reset was asserted");

endmodule

bind muldiv_unit muldiv_unit_props u_props
(
  .clk     (clk),
  .reset   (reset),
  .start   (start),
  .done    (done),
  .illegal (illegal)
);

//--- testbench/muldiv_unit_tb.sv
`timescale 1ns/1ps

`include "muldiv_settings.svh"

module muldiv_unit_tb
  import riscv_m_pkg::*;
();

  // directed tests run to about 1000 cycles and the limit is twice that
  localparam int TEST_CYCLES    = 1000;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic        clk;
  logic        reset;
  logic        start;
  logic [31:0] instr;
  xw_t         rs1;
  xw_t         rs2;
  logic        done;
  logic        illegal;
  reg_idx_t    rd_idx;
  xw_t         rd;

  int          errors = 0;
  int          checks = 0;
  int          cycle_count = 0;
  logic [31:0] lcg_state = 32'h9aed913d;

  // pending words for the next batch
  logic [31:0] q_instr[$];
  logic [31:0] q_a[$];
  logic [31:0] q_b[$];

  muldiv_unit UUT
  (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .instr   (instr),
    .rs1     (rs1),
    .rs2     (rs2),
    .done    (done),
    .illegal (illegal),
    .rd_idx  (rd_idx),
    .rd      (rd)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // hang guard
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // LCG with numerical recipes constants
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // random destination that is never x0
  function automatic logic [4:0] rand_rd();
    logic [31:0] r;
    r = next_rand();
    return (r[4:0] == 5'd0) ? 5'd9 : r[4:0];
  endfunction

  // R-type word whose rs1 and rs2 fields the unit ignores
  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd_f, input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, rd_f, opc};
  endfunction

  function automatic logic [31:0] m_word(input logic [2:0] f3, input logic [4:0] rd_f);
    return r_word(`MULDIV_F7_M, f3, rd_f, `MULDIV_OPC_OP);
  endfunction

  // expected value straight from the RV32M rules
  function automatic logic [31:0] ref_result(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b);
    logic signed [63:0] p_ss;
    logic signed [63:0] p_su;
    logic [63:0]        p_uu;
    int                 sa;
    int                 sb;
    logic               ovf;
    sa   = a;
    sb   = b;
    ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    p_ss = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    p_su = $signed({{32{a[31]}}, a}) * $signed({32'd0, b});
    p_uu = {32'd0, a} * {32'd0, b};
    // x/0 gives all ones as quotient and the dividend as remainder
    if ((f3 >= 3'd4) && (b == 0))
      return f3[1] ? a : 32'hffff_ffff;
    // signed overflow gives the most negative value and a zero remainder
    if (((f3 == 3'd4) || (f3 == 3'd6)) && ovf)
      return f3[1] ? 32'd0 : 32'h8000_0000;
    case (f3)
      3'd0: return p_ss[31:0];
      3'd1: return p_ss[63:32];
      3'd2: return p_su[63:32];
      3'd3: return p_uu[63:32];
      3'd4: return sa / sb;
      3'd5: return a / b;
      3'd6: return sa % sb;
      default: return a % b;
    endcase
  endfunction

  task automatic push_item(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b);
    q_instr.push_back(w);
    q_a.push_back(a);
    q_b.push_back(b);
  endtask

  // compare one retired word against the model
  task automatic check_item(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b);
    logic        is_m;
    logic [4:0]  exp_rd;
    logic [31:0] exp_val;
    is_m    = (w[6:0] == `MULDIV_OPC_OP) && (w[31:25] == `MULDIV_F7_M);
    exp_rd  = w[11:7];
    exp_val = (exp_rd == 5'd0) ? 32'd0 : ref_result(w[14:12], a, b);
    checks++;
    assert ((done === is_m) && (illegal === !is_m))
    else
    begin
      errors++;
      $display("Mismatch at %0t: word %h done=%b illegal=%b, expected legal=%b",
               $time, w, done, illegal, is_m);
    end
    if (is_m)
    begin
      assert ((rd_idx === exp_rd) && (rd === exp_val))
      else
      begin
        errors++;
        $display("Mismatch at %0t: word %h a=%h b=%h got x%0d=%h, expected x%0d=%h",
                 $time, w, a, b, rd_idx, rd, exp_rd, exp_val);
      end
    end
  endtask

  // drive the queued words back to back with results trailing by two cycles
  task automatic run_queue();
    int n;
    n = q_instr.size();
    for (int k = 0; k < n + 2; k++)
    begin
      @(posedge clk);
      if (k < n)
      begin
        start <= 1'b1;
        instr <= q_instr[k];
        rs1   <= q_a[k];
        rs2   <= q_b[k];
      end
      else
        start <= 1'b0;
      @(negedge clk);
      if (k >= 2)
        check_item(q_instr[k-2], q_a[k-2], q_b[k-2]);
    end
    // strobes drop once the batch has drained
    @(posedge clk);
    @(negedge clk);
    checks++;
    assert (!done && !illegal)
    else
    begin
      errors++;
      $display("Mismatch at %0t: strobe still high after batch", $time);
    end
    q_instr.delete();
    q_a.delete();
    q_b.delete();
  endtask

  task automatic test_all_forms();
    logic [31:0] a;
    logic [31:0] b;
    for (int f = 0; f < 8; f++)
    begin
      for (int i = 0; i < 30; i++)
      begin
        a = next_rand();
        b = next_rand();
        // shrink some divisors so quotients are not just 0 or 1
        if (i[0])
          b = b >> b[4:0];
        push_item(m_word(3'(f), rand_rd()), a, b);
        run_queue();
      end
    end
  endtask

  task automatic test_div_by_zero();
    logic [31:0] dividends[3];
    dividends[0] = next_rand();
    dividends[1] = 32'h8000_0000;
    dividends[2] = 32'h0000_0007;
    for (int f = 4; f < 8; f++)
      for (int i = 0; i < 3; i++)
      begin
        push_item(m_word(3'(f), rand_rd()), dividends[i], 32'd0);
        run_queue();
      end
  endtask

  // unsigned forms on the same operands must not take the override
  task automatic test_overflow();
    for (int f = 4; f < 8; f++)
    begin
      push_item(m_word(3'(f), rand_rd()), 32'h8000_0000, 32'hffff_ffff);
      run_queue();
    end
  endtask

  task automatic test_back_to_back();
    logic [31:0] r;
    for (int i = 0; i < 16; i++)
    begin
      r = next_rand();
      push_item(m_word(r[2:0], rand_rd()), next_rand(), next_rand() >> r[7:3]);
    end
    run_queue();
  endtask

  // ADD, SUB and an OP-IMM word are not M
  // x0 results read as zero
  task automatic test_illegal_and_x0();
    push_item(r_word(7'b0000000, 3'b000, 5'd3, `MULDIV_OPC_OP), 32'd5, 32'd6);
    push_item(m_word(3'd0, 5'd0), 32'd1234, 32'd5678);
    push_item(r_word(`MULDIV_F7_M, 3'b000, 5'd4, 7'b0010011), 32'd7, 32'd8);
    push_item(m_word(3'd4, 5'd0), 32'd100, 32'd7);
    push_item(m_word(3'd3, 5'd7), 32'hffff_ffff, 32'hffff_ffff);
    push_item(r_word(7'b0100000, 3'b000, 5'd8, `MULDIV_OPC_OP), 32'd9, 32'd1);
    run_queue();
  endtask

  initial
  begin
    reset = 1'b1;
    start = 1'b0;
    instr = '0;
    rs1   = '0;
    rs2   = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    test_all_forms();
    test_div_by_zero();
    test_overflow();
    test_back_to_back();
    test_illegal_and_x0();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- build.f
+incdir+design
design/riscv_m_pkg.sv
design/m_issue_if.sv
design/m_decode.sv
design/m_execute.sv
design/m_result.sv
design/muldiv_unit.sv
testbench/muldiv_unit_props.sv
testbench/muldiv_unit_tb.sv

//--- Bender.yml
package:
  name: muldiv_unit

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/riscv_m_pkg.sv
      - design/m_issue_if.sv
      - design/m_decode.sv
      - design/m_execute.sv
      - design/m_result.sv
      - design/muldiv_unit.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - testbench/muldiv_unit_props.sv
      - testbench/muldiv_unit_tb.sv
